/* design/safe_domain_pad_pkg.sv */
`default_nettype none

package safe_domain_pad_pkg;

        // ****************************************
        // Pad counts
        // ****************************************

        // Default number of pads handled by the safe domain
        localparam int unsigned NUM_PADS_DEF = 8;

        // Alternate peripheral channels that can own a pad
        localparam int unsigned NUM_ALT = 3;

        // ****************************************
        // Pad side types
        // ****************************************

        // Function select per pad, GPIO after reset
        typedef enum logic [1:0]
        {
                PAD_FUNC_GPIO = 2'd0,
                PAD_FUNC_ALT0 = 2'd1,
                PAD_FUNC_ALT1 = 2'd2,
                PAD_FUNC_ALT2 = 2'd3
        } pad_func_e;

        // Electrical settings, handed to the pad frame untouched
        typedef logic [5:0] pad_cfg_t;

        // Drive request of one alternate channel toward its pad
        typedef struct packed
        {
                logic out;
                logic oe;
        } alt_drive_t;

        // Final drive of one pad
        typedef struct packed
        {
                logic out;
                logic oe;
        } pad_drive_t;

endpackage

`default_nettype wire

/* design/safe_domain_cfg_pkg.sv */
`default_nettype none

package safe_domain_cfg_pkg;

        // ****************************************
        // Configuration write port
        // ****************************************

        // Address selects the pad, so up to 256 pads
        localparam int unsigned CFG_ADDR_W = 8;

        typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

        // Bits 7:6 function select, bits 5:0 pad configuration
        typedef logic [7:0] cfg_data_t;

        // One write request, held stable until accepted
        typedef struct packed
        {
                cfg_addr_t addr;
                cfg_data_t data;
        } cfg_wr_req_t;

endpackage

`default_nettype wire

/* design/rst_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module rst_sync
(
        input  logic clk_i,
        input  logic arst_n_i,
        output logic rst_n_o
);

        logic rst_meta_q;
        logic rst_sync_q;

        // Assert at once, release after two clock edges
        always_ff @(posedge clk_i or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        rst_meta_q <= 1'b0;
                        rst_sync_q <= 1'b0;
                end
                else
                begin
                        rst_meta_q <= 1'b1;
                        rst_sync_q <= rst_meta_q;
                end
        end

        assign rst_n_o = rst_sync_q;

        // Release needs the async reset high over the two previous edges
        a_no_early_release: assert property (@(posedge clk_i)
                $rose(rst_n_o) |-> arst_n_i && $past(arst_n_i));

endmodule

`default_nettype wire

/* design/pad_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module pad_cfg_regs
#(
        parameter int unsigned NUM_PADS = safe_domain_pad_pkg::NUM_PADS_DEF
)
(
        input  logic                                          clk_i,
        input  logic                                          rst_n_i,

        // Configuration write port
        input  logic                                          cfg_wr_valid_i,
        output logic                                          cfg_wr_ready_o,
        input  safe_domain_cfg_pkg::cfg_wr_req_t              cfg_wr_req_i,

        // Per pad settings
        output safe_domain_pad_pkg::pad_func_e [NUM_PADS-1:0] pad_func_o,
        output safe_domain_pad_pkg::pad_cfg_t  [NUM_PADS-1:0] pad_cfg_o
);

        import safe_domain_pad_pkg::*;
        import safe_domain_cfg_pkg::*;

        // Function select sits above the pad configuration in the data byte
        localparam int unsigned FUNC_LSB = $bits(pad_cfg_t);
        localparam int unsigned DATA_MSB = $bits(cfg_data_t) - 1;

        pad_func_e [NUM_PADS-1:0] func_q;
        pad_cfg_t  [NUM_PADS-1:0] cfg_q;
        logic                     wr_en;

        // Ready is the synchronized reset release, no other back-pressure
        assign cfg_wr_ready_o = rst_n_i;
        assign wr_en          = cfg_wr_valid_i & cfg_wr_ready_o;

        // ****************************************
        // Register file
        // ****************************************

        // Addresses at or above NUM_PADS match no pad and are dropped
        always_ff @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        for (int i = 0; i < NUM_PADS; i++)
                        begin
                                func_q[i] <= PAD_FUNC_GPIO;
                                cfg_q[i]  <= '0;
                        end
                end
                else if (wr_en)
                begin
                        for (int i = 0; i < NUM_PADS; i++)
                        begin
                                if (cfg_wr_req_i.addr == cfg_addr_t'(i))
                                begin
                                        func_q[i] <= pad_func_e'(cfg_wr_req_i.data[DATA_MSB:FUNC_LSB]);
                                        cfg_q[i]  <= cfg_wr_req_i.data[FUNC_LSB-1:0];
                                end
                        end
                end
        end

        assign pad_func_o = func_q;
        assign pad_cfg_o  = cfg_q;

        // A stalled request may be withdrawn but must not change
        a_req_stable: assert property (@(posedge clk_i)
                cfg_wr_valid_i && !cfg_wr_ready_o
                |=> !cfg_wr_valid_i || $stable(cfg_wr_req_i));

endmodule

`default_nettype wire

/* design/pad_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module pad_mux
#(
        parameter int unsigned NUM_PADS = safe_domain_pad_pkg::NUM_PADS_DEF
)
(
        input  logic                                          clk_i,
        input  logic                                          rst_n_i,

        // Function select from the register block
        input  safe_domain_pad_pkg::pad_func_e [NUM_PADS-1:0] pad_func_i,

        // Drive sources
        input  logic [NUM_PADS-1:0]                           gpio_out_i,
        input  logic [NUM_PADS-1:0]                           gpio_dir_i,
        input  safe_domain_pad_pkg::alt_drive_t
                [NUM_PADS-1:0][safe_domain_pad_pkg::NUM_ALT-1:0] alt_drive_i,

        // Pad frame
        input  logic [NUM_PADS-1:0]                           pad_in_i,
        output safe_domain_pad_pkg::pad_drive_t [NUM_PADS-1:0] pad_drive_o,

        // Synchronized inputs back to the SoC
        output logic [NUM_PADS-1:0]                           gpio_in_o,
        output logic [NUM_PADS-1:0]                           alt_in_o
);

        import safe_domain_pad_pkg::*;

        logic [NUM_PADS-1:0] in_meta_q;
        logic [NUM_PADS-1:0] in_sync_q;

        // ****************************************
        // Output and enable selection
        // ****************************************

        always_comb
        begin
                alt_drive_t sel;

                for (int i = 0; i < NUM_PADS; i++)
                begin
                        case (pad_func_i[i])
                                PAD_FUNC_ALT0: sel = alt_drive_i[i][0];
                                PAD_FUNC_ALT1: sel = alt_drive_i[i][1];
                                PAD_FUNC_ALT2: sel = alt_drive_i[i][2];
                                // GPIO
                                default:
                                begin
                                        sel.out = gpio_out_i[i];
                                        sel.oe  = gpio_dir_i[i];
                                end
                        endcase
                        pad_drive_o[i].out = sel.out;
                        pad_drive_o[i].oe  = sel.oe;
                end
        end

        // ****************************************
        // Input synchronizers and routing
        // ****************************************

        always_ff @(posedge clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        in_meta_q <= '0;
                        in_sync_q <= '0;
                end
                else
                begin
                        in_meta_q <= pad_in_i;
                        in_sync_q <= in_meta_q;
                end
        end

        assign gpio_in_o = in_sync_q;

        // Alternate channel only sees its pad while it owns it
        always_comb
        begin
                for (int i = 0; i < NUM_PADS; i++)
                begin
                        alt_in_o[i] = (pad_func_i[i] != PAD_FUNC_GPIO) & in_sync_q[i];
                end
        end

        // Register block must hand over a known function code
        for (genvar g = 0; g < NUM_PADS; g++)
        begin : g_func_chk
                a_func_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                        !$isunknown(pad_func_i[g]));
        end

endmodule

`default_nettype wire

/* design/safe_domain.sv */
`timescale 1ns/100ps
`default_nettype none

module safe_domain
#(
        parameter int unsigned NUM_PADS = safe_domain_pad_pkg::NUM_PADS_DEF
)
(
        input  logic                                          ref_clk_i,
        input  logic                                          arst_n_i,
        output logic                                          rst_n_o,

        // ****************************************
        // Configuration write port
        // ****************************************
        input  logic                                          cfg_wr_valid_i,
        output logic                                          cfg_wr_ready_o,
        input  safe_domain_cfg_pkg::cfg_wr_req_t              cfg_wr_req_i,

        // ****************************************
        // Peripheral side
        // ****************************************
        input  logic [NUM_PADS-1:0]                           gpio_out_i,
        input  logic [NUM_PADS-1:0]                           gpio_dir_i,
        input  safe_domain_pad_pkg::alt_drive_t
                [NUM_PADS-1:0][safe_domain_pad_pkg::NUM_ALT-1:0] alt_drive_i,
        output logic [NUM_PADS-1:0]                           gpio_in_o,
        output logic [NUM_PADS-1:0]                           alt_in_o,

        // ****************************************
        // Pad frame side
        // ****************************************
        input  logic [NUM_PADS-1:0]                           pad_in_i,
        output safe_domain_pad_pkg::pad_drive_t [NUM_PADS-1:0] pad_drive_o,
        output safe_domain_pad_pkg::pad_cfg_t  [NUM_PADS-1:0] pad_cfg_o
);

        import safe_domain_pad_pkg::*;

        logic                     rst_n_sync;
        pad_func_e [NUM_PADS-1:0] pad_func;

        // Reset for everything clocked by the reference clock
        rst_sync i_rst_sync
        (
                .clk_i    ( ref_clk_i  ),
                .arst_n_i ( arst_n_i   ),
                .rst_n_o  ( rst_n_sync )
        );

        assign rst_n_o = rst_n_sync;

        pad_cfg_regs #(.NUM_PADS(NUM_PADS)) i_pad_cfg_regs
        (
                .clk_i          ( ref_clk_i      ),
                .rst_n_i        ( rst_n_sync     ),
                .cfg_wr_valid_i ( cfg_wr_valid_i ),
                .cfg_wr_ready_o ( cfg_wr_ready_o ),
                .cfg_wr_req_i   ( cfg_wr_req_i   ),
                .pad_func_o     ( pad_func       ),
                .pad_cfg_o      ( pad_cfg_o      )
        );

        pad_mux #(.NUM_PADS(NUM_PADS)) i_pad_mux
        (
                .clk_i       ( ref_clk_i   ),
                .rst_n_i     ( rst_n_sync  ),
                .pad_func_i  ( pad_func    ),
                .gpio_out_i  ( gpio_out_i  ),
                .gpio_dir_i  ( gpio_dir_i  ),
                .alt_drive_i ( alt_drive_i ),
                .pad_in_i    ( pad_in_i    ),
                .pad_drive_o ( pad_drive_o ),
                .gpio_in_o   ( gpio_in_o   ),
                .alt_in_o    ( alt_in_o    )
        );

endmodule

`default_nettype wire

/* verif/tb_safe_domain.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_safe_domain;

        import safe_domain_pad_pkg::*;
        import safe_domain_cfg_pkg::*;

        localparam int unsigned NUM_PADS       = 8;
        localparam int          TIMEOUT_CYCLES = 2000;

        logic                                   ref_clk;
        logic                                   arst_n;
        logic                                   rst_n;
        logic                                   cfg_wr_valid;
        logic                                   cfg_wr_ready;
        cfg_wr_req_t                            cfg_wr_req;
        logic [NUM_PADS-1:0]                    gpio_out;
        logic [NUM_PADS-1:0]                    gpio_dir;
        alt_drive_t [NUM_PADS-1:0][NUM_ALT-1:0] alt_drive;
        logic [NUM_PADS-1:0]                    pad_in;
        pad_drive_t [NUM_PADS-1:0]              pad_drive;
        pad_cfg_t [NUM_PADS-1:0]                pad_cfg;
        logic [NUM_PADS-1:0]                    gpio_in;
        logic [NUM_PADS-1:0]                    alt_in;

        // Expected contents of the register block
        pad_func_e exp_func [NUM_PADS];
        pad_cfg_t  exp_cfg  [NUM_PADS];
        int        cycle_cnt = 0;

        safe_domain #(.NUM_PADS(NUM_PADS)) dut0
        (
                .ref_clk_i      ( ref_clk      ),
                .arst_n_i       ( arst_n       ),
                .rst_n_o        ( rst_n        ),
                .cfg_wr_valid_i ( cfg_wr_valid ),
                .cfg_wr_ready_o ( cfg_wr_ready ),
                .cfg_wr_req_i   ( cfg_wr_req   ),
                .gpio_out_i     ( gpio_out     ),
                .gpio_dir_i     ( gpio_dir     ),
                .alt_drive_i    ( alt_drive    ),
                .gpio_in_o      ( gpio_in      ),
                .alt_in_o       ( alt_in       ),
                .pad_in_i       ( pad_in       ),
                .pad_drive_o    ( pad_drive    ),
                .pad_cfg_o      ( pad_cfg      )
        );

        initial ref_clk = 1'b0;
        always #50 ref_clk = ~ref_clk;

        always @(posedge ref_clk)
        begin
                cycle_cnt++;
                if (cycle_cnt > TIMEOUT_CYCLES)
                begin
                        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
                        $display("SIMULATION FAILED");
                        $fatal(1, "Cycle limit reached");
                end
        end

        // ****************************************
        // Compare tasks
        // ****************************************

        task automatic report_mismatch(input string name, input string exp, input string act);
                $display("Fail at %0t ns: %s expected %s, actual %s", $time, name, exp, act);
                $display("SIMULATION FAILED");
                $fatal(1, "Mismatch on %s", name);
        endtask

        task automatic compare_drive(input string name, input pad_drive_t exp,
                                     input pad_drive_t act);
                if (act !== exp)
                        report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
        endtask

        task automatic compare_cfg(input string name, input pad_cfg_t exp, input pad_cfg_t act);
                if (act !== exp)
                        report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
        endtask

        task automatic compare_bit(input string name, input logic exp, input logic act);
                if (act !== exp)
                        report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
        endtask

        // ****************************************
        // Model and helpers
        // ****************************************

        task automatic clear_model();
                for (int p = 0; p < NUM_PADS; p++)
                begin
                        exp_func[p] = PAD_FUNC_GPIO;
                        exp_cfg[p]  = '0;
                end
        endtask

        // GPIO owns the pad unless an ALTk code hands it to channel k
        function automatic pad_drive_t expected_drive(input int p);
                pad_drive_t d;
                int         k;
                if (exp_func[p] == PAD_FUNC_GPIO)
                begin
                        d.out = gpio_out[p];
                        d.oe  = gpio_dir[p];
                end
                else
                begin
                        k     = int'(exp_func[p]) - 1;
                        d.out = alt_drive[p][k].out;
                        d.oe  = alt_drive[p][k].oe;
                end
                return d;
        endfunction

        task automatic check_pads();
                for (int p = 0; p < NUM_PADS; p++)
                begin
                        compare_drive($sformatf("pad_drive_o[%0d]", p), expected_drive(p),
                                      pad_drive[p]);
                        compare_cfg($sformatf("pad_cfg_o[%0d]", p), exp_cfg[p], pad_cfg[p]);
                end
        endtask

        task automatic check_inputs(input logic [NUM_PADS-1:0] sync_val);
                for (int p = 0; p < NUM_PADS; p++)
                begin
                        compare_bit($sformatf("gpio_in_o[%0d]", p), sync_val[p], gpio_in[p]);
                        compare_bit($sformatf("alt_in_o[%0d]", p),
                                    sync_val[p] & (exp_func[p] != PAD_FUNC_GPIO), alt_in[p]);
                end
        endtask

        task automatic check_reset_state();
                compare_bit("rst_n_o", 1'b0, rst_n);
                compare_bit("cfg_wr_ready_o", 1'b0, cfg_wr_ready);
                check_inputs('0);
                check_pads();
        endtask

        task automatic randomize_drives();
                logic [31:0]                            rnd;
                alt_drive_t [NUM_PADS-1:0][NUM_ALT-1:0] alt_tmp;
                @(posedge ref_clk);
                rnd = $urandom;
                gpio_out <= rnd[NUM_PADS-1:0];
                gpio_dir <= rnd[2*NUM_PADS-1:NUM_PADS];
                for (int p = 0; p < NUM_PADS; p++)
                begin
                        for (int k = 0; k < NUM_ALT; k++)
                        begin
                                rnd            = $urandom;
                                alt_tmp[p][k].out = rnd[0];
                                alt_tmp[p][k].oe  = rnd[1];
                        end
                end
                alt_drive <= alt_tmp;
        endtask

        // Holds the request until an edge with ready high, model follows after it
        task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
                logic accepted;
                int   idx;
                @(posedge ref_clk);
                cfg_wr_valid <= 1'b1;
                cfg_wr_req   <= {addr, data};
                accepted = 1'b0;
                while (!accepted)
                begin
                        @(negedge ref_clk);
                        accepted = cfg_wr_ready;
                        @(posedge ref_clk);
                end
                cfg_wr_valid <= 1'b0;
                idx = int'(addr);
                if (idx < int'(NUM_PADS))
                begin
                        exp_func[idx] = pad_func_e'(data[7:6]);
                        exp_cfg[idx]  = data[5:0];
                end
        endtask

        // ****************************************
        // Directed tests
        // ****************************************

        task automatic test_reset();
                repeat (4)
                begin
                        @(negedge ref_clk);
                        check_reset_state();
                end
                @(posedge ref_clk);
                arst_n <= 1'b1;
                @(negedge ref_clk);
                compare_bit("rst_n_o", 1'b0, rst_n);
                @(negedge ref_clk);
                compare_bit("rst_n_o", 1'b0, rst_n);
                @(negedge ref_clk);
                compare_bit("rst_n_o", 1'b1, rst_n);
                compare_bit("cfg_wr_ready_o", 1'b1, cfg_wr_ready);
        endtask

        task automatic test_gpio_mode();
                repeat (20)
                begin
                        randomize_drives();
                        @(negedge ref_clk);
                        check_pads();
                end
        endtask

        task automatic test_alt_select();
                logic [31:0] rnd;
                int          k;
                repeat (24)
                begin
                        rnd = $urandom;
                        k   = int'(rnd[7:3]) % NUM_ALT;
                        write_cfg(cfg_addr_t'(rnd[2:0]), {2'(k + 1), rnd[13:8]});
                        @(negedge ref_clk);
                        check_pads();
                        randomize_drives();
                        @(negedge ref_clk);
                        check_pads();
                end
        endtask

        task automatic test_input_path();
                logic [NUM_PADS-1:0] prev;
                logic [NUM_PADS-1:0] next;
                // Pad 0 back to GPIO so both routings are seen
                write_cfg(cfg_addr_t'(0), {2'b00, 6'h15});
                prev = '0;
                repeat (16)
                begin
                        next = NUM_PADS'($urandom);
                        @(posedge ref_clk);
                        pad_in <= next;
                        @(negedge ref_clk);
                        @(negedge ref_clk);
                        check_inputs(prev);
                        @(negedge ref_clk);
                        check_inputs(next);
                        prev = next;
                end
        endtask

        task automatic test_range_and_reset();
                logic [31:0] rnd;
                repeat (8)
                begin
                        rnd = $urandom;
                        write_cfg(cfg_addr_t'(8 + int'(rnd[7:0]) % 248), rnd[15:8]);
                        @(negedge ref_clk);
                        check_pads();
                end
                @(posedge ref_clk);
                arst_n <= 1'b0;
                clear_model();
                @(negedge ref_clk);
                check_reset_state();
                // Write stalls in reset and completes once ready returns
                fork
                        write_cfg(cfg_addr_t'(3), {2'b11, 6'h2a});
                        begin
                                repeat (3)
                                begin
                                        @(negedge ref_clk);
                                        check_reset_state();
                                end
                                @(posedge ref_clk);
                                arst_n <= 1'b1;
                        end
                join
                @(negedge ref_clk);
                check_pads();
        endtask

        initial
        begin
                void'($urandom(32'hebe6fea9));
                arst_n       <= 1'b0;
                cfg_wr_valid <= 1'b0;
                cfg_wr_req   <= '0;
                gpio_out     <= '0;
                gpio_dir     <= '0;
                alt_drive    <= '0;
                pad_in       <= '0;
                clear_model();

                test_reset();
                test_gpio_mode();
                test_alt_select();
                test_input_path();
                test_range_and_reset();

                $display("SIMULATION PASSED");
                $finish;
        end

endmodule

`default_nettype wire

/* safe_domain.f */
design/safe_domain_pad_pkg.sv
design/safe_domain_cfg_pkg.sv
design/rst_sync.sv
design/pad_cfg_regs.sv
design/pad_mux.sv
design/safe_domain.sv
verif/tb_safe_domain.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the safe domain testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_safe_domain -f safe_domain.f \
        -Mdir obj_dir -o tb_safe_domain > build.log 2>&1 \
        || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_safe_domain > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && echo "Result: PASS" || { echo "Result: no pass line"; exit 1; }
